// File: bench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic start,
    output logic rstN
);

    initial begin
        start = 1'b0;
        forever #(PERIOD_NS / 2) start = ~start;
    end

    // reset held over the first RESET_CYCLES rising edges
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge start);
        #1 rstN = 1'b1;  // released off the edge like the other inputs
    end

endmodule

// File: bench/mulBench.sv
`timescale 1ns/1ps

module mulBench
    import mulDataPkg::*, mulCtrlPkg::*;
();

    localparam int WIDTH      = DATA_W;
    localparam int DIR_N      = 11;
    localparam int RAND_N     = 200;
    localparam int B2B_N      = 3;
    localparam int NUM_OPS    = DIR_N + RAND_N + B2B_N + 1;  // +1 for the ignored go run
    localparam int OP_CYCLES  = 2 * WIDTH + 4;                // run plus idle gap and slack
    localparam int MAX_CYCLES = NUM_OPS * OP_CYCLES * 4 / 3 + 100;
    localparam int DRIVE_DLY  = 1;

    logic    start;
    logic    rstN;
    logic    go;
    operand  a;
    operand  b;
    prodWord p;
    logic    finish;
    mulPhase dutPhase;  // only for messages

    integer  seed      = 32'h0c21_c0bc;
    int      prodErrs  = 0;
    int      levelErrs = 0;
    int      otherErrs = 0;
    int      issued    = 0;
    int      checked   = 0;
    int      cycleCnt  = 0;
    prodWord expQ [$];  // one entry per accepted go

    // zero, one, all ones and powers of two on either side
    operand dirA [DIR_N] = '{
        32'h0000_0000, 32'hdead_beef, 32'h0000_0001, 32'h1357_9bdf,
        32'hffff_ffff, 32'h8000_0000, 32'h0001_0000, 32'h0000_0100,
        32'h2468_ace0, 32'hffff_ffff, 32'h0000_0000
    };
    operand dirB [DIR_N] = '{
        32'h1234_5678, 32'h0000_0000, 32'h9abc_def0, 32'h0000_0001,
        32'hffff_ffff, 32'hffff_ffff, 32'h8765_4321, 32'hcafe_f00d,
        32'h8000_0000, 32'h0000_0001, 32'h0000_0000
    };

    clockGen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (10)
    ) uClock (
        .start (start),
        .rstN  (rstN)
    );

    shiftAddMul #(
        .WIDTH (WIDTH)
    ) u_dut (
        .start  (start),
        .rstN   (rstN),
        .go     (go),
        .a      (a),
        .b      (b),
        .p      (p),
        .finish (finish)
    );

    assign dutPhase = u_dut.uControl.phase;

    // plain 64 bit product of the zero extended operands
    function automatic prodWord refProduct(input operand x, input operand y);
        prodWord             r;
        logic [2*DATA_W-1:0] wideX;
        logic [2*DATA_W-1:0] wideY;
        wideX  = {{DATA_W{1'b0}}, x};
        wideY  = {{DATA_W{1'b0}}, y};
        r.full = wideX * wideY;
        return r;
    endfunction

    task automatic checkProd(input prodWord expVal, input prodWord actVal, input string what);
        if (actVal.full !== expVal.full) begin
            prodErrs++;
            $display("Fail at %0t: %s, expected hi %h lo %h, got hi %h lo %h", $time, what,
                     expVal.halves.hi, expVal.halves.lo, actVal.halves.hi, actVal.halves.lo);
        end
    endtask

    task automatic checkLevel(input logic expVal, input logic actVal, input string what);
        if (actVal !== expVal) begin
            levelErrs++;
            $display("Fail at %0t: %s, expected %b, got %b (phase %s)", $time, what,
                     expVal, actVal, dutPhase.name());
        end
    endtask

    // one rising edge, then the drive and sample point
    task automatic waitCycle();
        @(posedge start);
        #(DRIVE_DLY);
    endtask

    // caller sits at a sample point with finish high
    task automatic issueGo(input operand x, input operand y);
        go = 1'b1;
        a  = x;
        b  = y;
        expQ.push_back(refProduct(x, y));
        issued++;
        waitCycle();
        go = 1'b0;
        a  = ~x;  // operands must already be captured
        b  = ~y;
        checkLevel(1'b0, finish, "finish after accepted go");
    endtask

    // finish is expected exactly 2*WIDTH edges after the accepting one
    task automatic waitFinish(input logic injectGo, input operand x, input operand y);
        int cycles;
        cycles = 0;
        while (!finish && cycles < 2 * WIDTH) begin
            if (injectGo && cycles == 5) begin
                go = 1'b1;  // busy, must be dropped
                a  = x;
                b  = y;
            end else begin
                go = 1'b0;
            end
            waitCycle();
            cycles++;
            checkLevel(cycles == 2 * WIDTH, finish, "finish timing");
        end
        go = 1'b0;
        while (!finish) begin
            waitCycle();  // late finish already reported
        end
    endtask

    task automatic multiply(input operand x, input operand y);
        issueGo(x, y);
        waitFinish(1'b0, '0, '0);
    endtask

    // compares p on every rise of finish, and holds it while idle
    initial begin
        prodWord held;
        prodWord expVal;
        logic    finPrev;
        held    = '0;
        finPrev = 1'b1;
        wait (rstN === 1'b1);
        forever begin
            @(posedge start);
            #(DRIVE_DLY);
            if (finish && !finPrev) begin
                if (expQ.size() == 0) begin
                    otherErrs++;
                    $display("finish rose at %0t without a started multiplication", $time);
                end else begin
                    expVal = expQ.pop_front();
                    checkProd(expVal, p, "product at finish");
                    checked++;
                end
                held = p;
            end else if (finish && finPrev) begin
                checkProd(held, p, "product changed while idle");
            end
            finPrev = finish;
        end
    end

    initial begin
        while (cycleCnt < MAX_CYCLES) begin
            @(posedge start);
            cycleCnt++;
        end
        $display("timeout after %0d cycles, the test did not complete (phase %s)",
                 cycleCnt, dutPhase.name());
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        operand ra;
        operand rb;
        go = 1'b0;
        a  = '0;
        b  = '0;
        wait (rstN === 1'b1);
        waitCycle();
        checkLevel(1'b1, finish, "finish after reset");
        checkProd('0, p, "product after reset");

        for (int i = 0; i < DIR_N; i++) begin
            multiply(dirA[i], dirB[i]);
            waitCycle();  // one idle cycle between runs
        end

        // odd ra goes back-to-back, even ra leaves a gap
        for (int i = 0; i < RAND_N; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            multiply(ra, rb);
            if (!ra[0]) begin
                waitCycle();
            end
        end

        // second go lands mid run and must not disturb it
        issueGo(32'h0bad_f00d, 32'h7654_3210);
        waitFinish(1'b1, 32'hffff_ffff, 32'hffff_ffff);
        repeat (2) begin
            waitCycle();
            checkLevel(1'b1, finish, "finish after ignored go");
        end

        for (int i = 0; i < B2B_N; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            multiply(ra, rb);  // next go in the first idle cycle
        end

        repeat (3) waitCycle();
        if (checked != issued) begin
            otherErrs++;
            $display("only %0d of %0d multiplications reached finish", checked, issued);
        end
        $display("runs %0d, checked %0d, errors: product %0d, level %0d, other %0d",
                 issued, checked, prodErrs, levelErrs, otherErrs);
        if (prodErrs + levelErrs + otherErrs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: logic/mulControl.sv
`timescale 1ns/1ps

module mulControl
    import mulCtrlPkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic  start,
    input  logic  rstN,
    input  logic  go,
    output mulCmd cmd,
    output logic  finish
);

    // counter has to hold WIDTH itself after the last shift
    localparam int CNT_W = $clog2(WIDTH + 1);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(WIDTH - 1);
    localparam logic [CNT_W-1:0] MAX_CNT  = CNT_W'(WIDTH);

    mulPhase          phase;
    logic [CNT_W-1:0] bitCnt;  // completed bits
    logic             accept;

    // go only counts while idle, a busy unit drops it
    assign accept = go && (phase == phIdle);

    // command decode straight from the phase
    // load goes out in the same cycle go is seen
    always_comb begin
        cmd           = '0;
        cmd.load      = accept;
        cmd.addStep   = (phase == phAdd);
        cmd.shiftStep = (phase == phShift);
    end

    always_ff @(posedge start) begin
        if (!rstN) begin
            phase  <= phIdle;
            bitCnt <= '0;
            finish <= 1'b1;  // idle out of reset, product reads zero
        end else begin
            case (phase)
                phIdle: begin
                    if (accept) begin
                        phase  <= phAdd;  // first add on the next edge
                        bitCnt <= '0;
                        finish <= 1'b0;
                    end
                end
                phAdd: begin
                    phase <= phShift;
                end
                phShift: begin
                    bitCnt <= bitCnt + 1'b1;
                    if (bitCnt == LAST_BIT) begin
                        // last shift lands on this edge, result is complete
                        phase  <= phIdle;
                        finish <= 1'b1;
                    end else begin
                        phase <= phAdd;
                    end
                end
                default: begin
                    phase  <= phIdle;  // unused encoding
                    finish <= 1'b1;
                end
            endcase
        end
    end

    // bit counter stops at WIDTH and is only cleared by the next load
    assert property (@(posedge start) disable iff (!rstN)
        bitCnt <= MAX_CNT)
        else $error("mulControl: bit counter past WIDTH");

    // finish is its own register, it must track the idle phase
    assert property (@(posedge start) disable iff (!rstN)
        finish == (phase == phIdle))
        else $error("mulControl: finish out of step with phase");

    // datapath relies on a single action per edge
    assert property (@(posedge start) disable iff (!rstN)
        $onehot0(cmd))
        else $error("mulControl: more than one command bit set");

endmodule

// File: logic/mulCtrlPkg.sv
package mulCtrlPkg;

    // sequencer phases
    // one add phase and one shift phase per multiplier bit
    typedef enum logic [1:0] {
        phIdle,   // product valid, waiting for go
        phAdd,    // conditional add of the multiplicand
        phShift   // shift carry, hi and lo right by one
    } mulPhase;

    // command from the sequencer to the datapath
    // at most one bit is set in any cycle
    typedef struct packed {
        logic load;       // capture operands, clear hi and carry
        logic addStep;    // add multiplicand into hi when lo[0] is set
        logic shiftStep;  // {carry, hi, lo} >> 1
    } mulCmd;

endpackage

// File: logic/mulDataPkg.sv
package mulDataPkg;

    // operand width of the package types
    // the top level WIDTH parameter has to agree with this
    localparam int DATA_W = 32;
    localparam int PROD_W = 2 * DATA_W;

    // unsigned multiplicand / multiplier word
    typedef logic [DATA_W-1:0] operand;

    // the product register split in two
    // hi holds the running sum and ends up as the upper product
    // lo starts as the multiplier, bits fall out of bit 0 one per shift,
    // and the lower product bits fill in from the top
    typedef struct packed {
        logic [DATA_W-1:0] hi;  // running sum
        logic [DATA_W-1:0] lo;  // multiplier, then low product
    } prodHalves;

    // same 64 bits read two ways
    // full for the result and the shift step,
    // halves for the add step and the operand load
    typedef union packed {
        logic [PROD_W-1:0] full;
        prodHalves         halves;
    } prodWord;

endpackage

// File: logic/productAccum.sv
`timescale 1ns/1ps

module productAccum
    import mulDataPkg::*, mulCtrlPkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic               start,
    input  logic               rstN,
    input  mulCmd              cmd,
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    output logic [2*WIDTH-1:0] prod
);

    // the product register is the package union, so its width is fixed
    if (WIDTH != DATA_W) begin : gWidthCheck
        $error("productAccum: WIDTH must equal mulDataPkg::DATA_W");
    end

    logic [WIDTH-1:0] mcand;    // multiplicand, held for the whole run
    prodWord          prodReg;  // {hi, lo}
    logic             carry;    // carry out of the last add
    logic [WIDTH:0]   sumExt;   // hi + multiplicand with carry

    assign sumExt = {1'b0, prodReg.halves.hi} + {1'b0, mcand};

    always_ff @(posedge start) begin
        if (!rstN) begin
            mcand   <= '0;
            prodReg <= '0;
            carry   <= 1'b0;
        end else if (cmd.load) begin
            mcand             <= a;
            prodReg.halves.hi <= '0;  // sum starts at zero
            prodReg.halves.lo <= b;   // multiplier goes in low half
            carry             <= 1'b0;
        end else if (cmd.addStep) begin
            // current multiplier bit sits at lo[0]
            if (prodReg.halves.lo[0]) begin
                {carry, prodReg.halves.hi} <= sumExt;
            end else begin
                carry <= 1'b0;  // nothing added, no carry to shift in
            end
        end else if (cmd.shiftStep) begin
            // carry drops into the top of hi, lo[0] falls off the bottom
            prodReg.full <= {carry, prodReg.full[2*WIDTH-1:1]};
            carry        <= 1'b0;
        end
    end

    assign prod = prodReg.full;

    // multiplicand is loaded once per run and never touched by add or shift
    assert property (@(posedge start) disable iff (!rstN)
        !cmd.load |=> $stable(mcand))
        else $error("productAccum: multiplicand changed without a load");

endmodule

// File: logic/shiftAddMul.sv
`timescale 1ns/1ps

module shiftAddMul
    import mulDataPkg::*, mulCtrlPkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic    start,
    input  logic    rstN,
    input  logic    go,      // one cycle strobe, taken only while finish is high
    input  operand  a,       // multiplicand
    input  operand  b,       // multiplier
    output prodWord p,
    output logic    finish   // idle and product valid
);

    mulCmd cmd;  // sequencer to datapath

    // phase sequencing, never looks at the data
    mulControl #(
        .WIDTH (WIDTH)
    ) uControl (
        .start  (start),
        .rstN   (rstN),
        .go     (go),
        .cmd    (cmd),
        .finish (finish)
    );

    // operand registers, adder and shifting product
    productAccum #(
        .WIDTH (WIDTH)
    ) uAccum (
        .start (start),
        .rstN  (rstN),
        .cmd   (cmd),
        .a     (a),
        .b     (b),
        .prod  (p.full)  // full view out, halves stay inside
    );

endmodule

// File: runSim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mulBench \
    -f shiftAddMul.f \
    --Mdir "$BUILD_DIR" \
    -o mulSim

"./$BUILD_DIR/mulSim" | tee "$LOG_FILE"

if grep -qF "*** TEST PASSED ***" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi

// File: shiftAddMul.f
logic/mulDataPkg.sv
logic/mulCtrlPkg.sv
logic/mulControl.sv
logic/productAccum.sv
logic/shiftAddMul.sv
bench/clockGen.sv
bench/mulBench.sv
